//--- hdl/mfPkg.sv
package mfPkg;

	// Width of one signed real input sample.
	localparam int DataWidth = 12;

	// Width of the real or the imaginary part of one coefficient.
	localparam int CoeffWidth = 12;

	// The complex FIR has eight taps, addressed by a three-bit index.
	localparam int NumTaps = 8;
	localparam int TapAddrWidth = 3;

	// The Hilbert filter is seven taps long with its centre at index three.
	localparam int HtLength = 7;
	localparam int HtCenter = 3;

	// Hilbert constants are in Q7, so the centre sample is scaled by 128.
	localparam int HtShift = 7;
	localparam int HtCoeff1 = 81;
	localparam int HtCoeff3 = 27;

	// Nine guard bits cover the Q7 scaling and the growth of the tap sum.
	localparam int HtOutWidth = DataWidth + 9;

	// Full width of one analytic part times one coefficient part.
	localparam int ProdWidth = HtOutWidth + CoeffWidth;

	// One bit for the cross term and log2 of the tap count for the sum.
	localparam int AccWidth = ProdWidth + 1 + $clog2(NumTaps);

	// A whole coefficient bank flattened into one vector.
	// Tap k sits in slice k.
	localparam int CoeffVecWidth = NumTaps * CoeffWidth;

	// Opcodes of the configuration port.
	typedef enum logic [1:0] {
		OpNop     = 2'd0,
		OpWriteRe = 2'd1,
		OpWriteIm = 2'd2,
		OpClear   = 2'd3
	} cfgOp_t;

endpackage

//--- hdl/mfCoeffRegs.sv
`timescale 1ns/1ps

module mfCoeffRegs (
	input  logic                                   clock,
	input  logic                                   arstN,
	input  logic                                   cfgWrite,
	input  mfPkg::cfgOp_t                          cfgOp,
	input  logic [mfPkg::TapAddrWidth-1:0]         cfgAddr,
	input  logic signed [mfPkg::CoeffWidth-1:0]    cfgData,
	output logic [mfPkg::CoeffVecWidth-1:0]        coeffRe,
	output logic [mfPkg::CoeffVecWidth-1:0]        coeffIm
);

	import mfPkg::*;

	// The two banks hold the complex impulse response, one entry per tap.
	logic signed [CoeffWidth-1:0] bankRe [NumTaps];
	logic signed [CoeffWidth-1:0] bankIm [NumTaps];

	// Decode a write strobe into a single slice update or a full clear.
	// The opcode, address and data are only looked at while cfgWrite is high.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k < NumTaps; k++) begin
				bankRe[k] <= '0;
				bankIm[k] <= '0;
			end
		end else if (cfgWrite) begin
			case (cfgOp)
				OpWriteRe: begin
					bankRe[cfgAddr] <= cfgData;
				end
				OpWriteIm: begin
					bankIm[cfgAddr] <= cfgData;
				end
				OpClear: begin
					for (int k = 0; k < NumTaps; k++) begin
						bankRe[k] <= '0;
						bankIm[k] <= '0;
					end
				end
				default: begin
					// Nothing to do for a no-op.
				end
			endcase
		end
	end

	// The banks are copied into the flattened outputs one cycle later.
	// A write strobed on cycle t then reaches the FIR on cycle t+2.
	// The FIR product stage of a sample strobed on cycle t runs on cycle t+1,
	// so that sample still multiplies the old value.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			coeffRe <= '0;
			coeffIm <= '0;
		end else begin
			for (int k = 0; k < NumTaps; k++) begin
				coeffRe[k*CoeffWidth +: CoeffWidth] <= bankRe[k];
				coeffIm[k*CoeffWidth +: CoeffWidth] <= bankIm[k];
			end
		end
	end

	// The write strobe must always be a clean level once out of reset.
	assert property (@(posedge clock) disable iff (!arstN) !$isunknown(cfgWrite))
		else $error("cfgWrite is unknown");

	// A host that strobes a write is expected to say what it wants done.
	assert property (@(posedge clock) disable iff (!arstN) cfgWrite |-> cfgOp != OpNop)
		else $error("write strobe carries OpNop");

endmodule

//--- hdl/hilbertTransform.sv
`timescale 1ns/1ps

module hilbertTransform (
	input  logic                                   clock,
	input  logic                                   arstN,
	input  logic                                   sampleValid,
	input  logic signed [mfPkg::DataWidth-1:0]     sampleIn,
	output logic                                   htValid,
	output logic signed [mfPkg::HtOutWidth-1:0]    htRe,
	output logic signed [mfPkg::HtOutWidth-1:0]    htIm
);

	import mfPkg::*;

	// Stored history holds the six samples before the current one.
	logic signed [DataWidth-1:0] delayLine [HtLength-1];

	// The full seven-sample window.
	// Index 0 holds the newest sample.
	logic signed [DataWidth-1:0] tapWindow [HtLength];

	// Differences of the samples that share a tap magnitude.
	logic signed [DataWidth:0] diffOne;
	logic signed [DataWidth:0] diffThree;

	// Next values of the two output parts.
	logic signed [HtOutWidth-1:0] reNext;
	logic signed [HtOutWidth-1:0] imNext;

	// The incoming sample joins the window in the same cycle it is strobed.
	// This keeps the output one cycle behind the input strobe.
	always_comb begin
		tapWindow[0] = sampleIn;
		for (int k = 1; k < HtLength; k++) begin
			tapWindow[k] = delayLine[k-1];
		end
	end

	// The filter is anti-symmetric about the centre, so older samples take
	// the positive constant and newer ones the negative.
	// Folding each pair into one difference halves the multiplier count.
	// The even taps are zero and are not built at all.
	always_comb begin
		diffOne = tapWindow[HtCenter+1] - tapWindow[HtCenter-1];
		diffThree = tapWindow[HtCenter+3] - tapWindow[HtCenter-3];
		imNext = diffOne * HtOutWidth'(HtCoeff1) + diffThree * HtOutWidth'(HtCoeff3);
	end

	// The real part is the centre sample brought into the same Q7 scale.
	assign reNext = HtOutWidth'(tapWindow[HtCenter]) <<< HtShift;

	// Valid follows the strobe every cycle.
	// The delay line and the outputs only move on a strobe, so gaps in the
	// input stream simply pause the filter.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			htValid <= 1'b0;
			htRe <= '0;
			htIm <= '0;
			for (int k = 0; k < HtLength - 1; k++) begin
				delayLine[k] <= '0;
			end
		end else begin
			htValid <= sampleValid;
			if (sampleValid) begin
				// Shift by one, so slot 0 takes the new sample.
				for (int k = 0; k < HtLength - 1; k++) begin
					delayLine[k] <= tapWindow[k];
				end
				htRe <= reNext;
				htIm <= imNext;
			end
		end
	end

	// Each analytic sample must appear exactly one cycle after its input.
	assert property (@(posedge clock) disable iff (!arstN) htValid == $past(sampleValid))
		else $error("htValid does not follow sampleValid by one cycle");

endmodule

//--- hdl/complexFir.sv
`timescale 1ns/1ps

module complexFir (
	input  logic                                   clock,
	input  logic                                   arstN,
	input  logic                                   htValid,
	input  logic signed [mfPkg::HtOutWidth-1:0]    htRe,
	input  logic signed [mfPkg::HtOutWidth-1:0]    htIm,
	input  logic [mfPkg::CoeffVecWidth-1:0]        coeffRe,
	input  logic [mfPkg::CoeffVecWidth-1:0]        coeffIm,
	output logic                                   outValid,
	output logic signed [mfPkg::AccWidth-1:0]      outRe,
	output logic signed [mfPkg::AccWidth-1:0]      outIm
);

	import mfPkg::*;

	// History of the seven analytic samples before the current one.
	logic signed [HtOutWidth-1:0] lineRe [NumTaps-1];
	logic signed [HtOutWidth-1:0] lineIm [NumTaps-1];

	// Full eight-sample window.
	// Tap 0 is the newest analytic sample.
	logic signed [HtOutWidth-1:0] winRe [NumTaps];
	logic signed [HtOutWidth-1:0] winIm [NumTaps];

	// Coefficients unpacked from the flattened banks.
	logic signed [CoeffWidth-1:0] tapRe [NumTaps];
	logic signed [CoeffWidth-1:0] tapIm [NumTaps];

	// Registered product stage with four real products per tap.
	logic signed [ProdWidth-1:0] prodReRe [NumTaps];
	logic signed [ProdWidth-1:0] prodImIm [NumTaps];
	logic signed [ProdWidth-1:0] prodReIm [NumTaps];
	logic signed [ProdWidth-1:0] prodImRe [NumTaps];
	logic prodValid;

	// Combinational sums of the product stage.
	logic signed [AccWidth-1:0] sumRe;
	logic signed [AccWidth-1:0] sumIm;

	// The arriving analytic sample sits in tap 0 during its valid cycle.
	always_comb begin
		winRe[0] = htRe;
		winIm[0] = htIm;
		for (int k = 1; k < NumTaps; k++) begin
			winRe[k] = lineRe[k-1];
			winIm[k] = lineIm[k-1];
		end
	end

	// Slice k of each bank belongs to tap k.
	always_comb begin
		for (int k = 0; k < NumTaps; k++) begin
			tapRe[k] = $signed(coeffRe[k*CoeffWidth +: CoeffWidth]);
			tapIm[k] = $signed(coeffIm[k*CoeffWidth +: CoeffWidth]);
		end
	end

	// Delay line and the valid pipeline.
	// Both valid bits move every cycle, so two samples can be in flight.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			prodValid <= 1'b0;
			outValid <= 1'b0;
			for (int k = 0; k < NumTaps - 1; k++) begin
				lineRe[k] <= '0;
				lineIm[k] <= '0;
			end
		end else begin
			prodValid <= htValid;
			outValid <= prodValid;
			if (htValid) begin
				for (int k = 0; k < NumTaps - 1; k++) begin
					lineRe[k] <= winRe[k];
					lineIm[k] <= winIm[k];
				end
			end
		end
	end

	// Products are only loaded with a valid sample.
	// The sum stage takes them on the next cycle, while prodValid is set.
	always_ff @(posedge clock) begin
		if (htValid) begin
			for (int k = 0; k < NumTaps; k++) begin
				prodReRe[k] <= winRe[k] * tapRe[k];
				prodImIm[k] <= winIm[k] * tapIm[k];
				prodReIm[k] <= winRe[k] * tapIm[k];
				prodImRe[k] <= winIm[k] * tapRe[k];
			end
		end
	end

	// Complex multiply rule, summed over all taps.
	// The accumulator is wide enough that nothing can wrap.
	always_comb begin
		sumRe = '0;
		sumIm = '0;
		for (int k = 0; k < NumTaps; k++) begin
			sumRe = sumRe + prodReRe[k] - prodImIm[k];
			sumIm = sumIm + prodReIm[k] + prodImRe[k];
		end
	end

	// Output registers hold their last result between samples.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			outRe <= '0;
			outIm <= '0;
		end else if (prodValid) begin
			outRe <= sumRe;
			outIm <= sumIm;
		end
	end

	// Every analytic sample leaves the filter two cycles after it arrives.
	assert property (@(posedge clock) disable iff (!arstN) outValid == $past(htValid, 2))
		else $error("outValid does not follow htValid by two cycles");

endmodule

//--- hdl/matchedFilter.sv
`timescale 1ns/1ps

module matchedFilter (
	input  logic                                   clock,
	input  logic                                   arstN,
	input  logic                                   cfgWrite,
	input  mfPkg::cfgOp_t                          cfgOp,
	input  logic [mfPkg::TapAddrWidth-1:0]         cfgAddr,
	input  logic signed [mfPkg::CoeffWidth-1:0]    cfgData,
	input  logic                                   sampleValid,
	input  logic signed [mfPkg::DataWidth-1:0]     sampleIn,
	output logic                                   outValid,
	output logic signed [mfPkg::AccWidth-1:0]      outRe,
	output logic signed [mfPkg::AccWidth-1:0]      outIm
);

	import mfPkg::*;

	// Flattened complex impulse response from the register block.
	logic [CoeffVecWidth-1:0] coeffRe;
	logic [CoeffVecWidth-1:0] coeffIm;

	// Analytic sample stream between the Hilbert stage and the FIR.
	logic htValid;
	logic signed [HtOutWidth-1:0] htRe;
	logic signed [HtOutWidth-1:0] htIm;

	// Coefficient store, written over the configuration port.
	mfCoeffRegs mfCoeffRegs_i (
		.clock    (clock),
		.arstN    (arstN),
		.cfgWrite (cfgWrite),
		.cfgOp    (cfgOp),
		.cfgAddr  (cfgAddr),
		.cfgData  (cfgData),
		.coeffRe  (coeffRe),
		.coeffIm  (coeffIm)
	);

	// Real to analytic conversion, one cycle of latency.
	hilbertTransform hilbertTransform_i (
		.clock       (clock),
		.arstN       (arstN),
		.sampleValid (sampleValid),
		.sampleIn    (sampleIn),
		.htValid     (htValid),
		.htRe        (htRe),
		.htIm        (htIm)
	);

	// Correlation against the stored taps, two more cycles of latency.
	complexFir complexFir_i (
		.clock    (clock),
		.arstN    (arstN),
		.htValid  (htValid),
		.htRe     (htRe),
		.htIm     (htIm),
		.coeffRe  (coeffRe),
		.coeffIm  (coeffIm),
		.outValid (outValid),
		.outRe    (outRe),
		.outIm    (outIm)
	);

endmodule

//--- dv/tbMatchedFilter.sv
`timescale 1ns/1ps

module tbMatchedFilter;

	import mfPkg::*;

	// Clock period in ns and the cycle budget of each test.
	// The budgets add up to the watchdog limit.
	localparam int ClockPeriod = 8;
	localparam int ResetCycles = 5;
	localparam int DrainLimit = 20;
	localparam int BudgetReset = 60;
	localparam int BudgetImpulse = 80;
	localparam int BudgetComplex = 60;
	localparam int BudgetClear = 80;
	localparam int BudgetRandom = 400;
	localparam int BudgetMargin = 100;
	localparam int TotalCycles = ResetCycles + BudgetReset + BudgetImpulse + BudgetComplex
		+ BudgetClear + BudgetRandom + BudgetMargin;
	localparam int ImpulseAmp = 100;

	logic clock;
	logic arstN;
	logic cfgWrite;
	cfgOp_t cfgOp;
	logic [TapAddrWidth-1:0] cfgAddr;
	logic signed [CoeffWidth-1:0] cfgData;
	logic sampleValid;
	logic signed [DataWidth-1:0] sampleIn;
	logic outValid;
	logic signed [AccWidth-1:0] outRe;
	logic signed [AccWidth-1:0] outIm;

	// Reference model state.
	// Index 0 is always the newest entry.
	longint htLine [HtLength];
	longint firRe [NumTaps];
	longint firIm [NumTaps];
	longint shadowRe [NumTaps];
	longint shadowIm [NumTaps];

	// Queues of expected results, of strobe cycles seen by the monitor and of captured outputs.
	longint expReQ [$];
	longint expImQ [$];
	int strobeQ [$];
	logic signed [AccWidth-1:0] capRe [$];
	logic signed [AccWidth-1:0] capIm [$];

	int cycleCount = 0;
	int valueErrors = 0;
	int protocolErrors = 0;
	int seed;
	string currentTest = "startup";

	matchedFilter matchedFilter_i (
		.clock       (clock),
		.arstN       (arstN),
		.cfgWrite    (cfgWrite),
		.cfgOp       (cfgOp),
		.cfgAddr     (cfgAddr),
		.cfgData     (cfgData),
		.sampleValid (sampleValid),
		.sampleIn    (sampleIn),
		.outValid    (outValid),
		.outRe       (outRe),
		.outIm       (outIm)
	);

	initial begin
		clock = 1'b0;
		forever #(ClockPeriod / 2) clock = ~clock;
	end

	// Compares one value and counts a mismatch.
	task automatic checkValue(input string name, input logic signed [63:0] expected,
		input logic signed [63:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
			valueErrors++;
		end
	endtask

	// Shadow of the coefficient banks, following the same opcode decode.
	function automatic void modelWrite(input cfgOp_t op, input int addr, input int data);
		case (op)
			OpWriteRe: shadowRe[addr] = data;
			OpWriteIm: shadowIm[addr] = data;
			OpClear: begin
				for (int k = 0; k < NumTaps; k++) begin
					shadowRe[k] = 0;
					shadowIm[k] = 0;
				end
			end
			default: begin
			end
		endcase
	endfunction

	// Pushes one real sample through the Hilbert and FIR rules and queues the result.
	function automatic void modelSample(input longint sample);
		longint aRe;
		longint aIm;
		longint accRe;
		longint accIm;
		for (int k = HtLength - 1; k > 0; k--) begin
			htLine[k] = htLine[k-1];
		end
		htLine[0] = sample;
		// Older neighbours carry the positive constants, newer ones the negative.
		aRe = htLine[HtCenter] * (longint'(1) << HtShift);
		aIm = HtCoeff1 * (htLine[HtCenter+1] - htLine[HtCenter-1])
			+ HtCoeff3 * (htLine[HtCenter+3] - htLine[HtCenter-3]);
		for (int k = NumTaps - 1; k > 0; k--) begin
			firRe[k] = firRe[k-1];
			firIm[k] = firIm[k-1];
		end
		firRe[0] = aRe;
		firIm[0] = aIm;
		accRe = 0;
		accIm = 0;
		for (int k = 0; k < NumTaps; k++) begin
			accRe += firRe[k] * shadowRe[k] - firIm[k] * shadowIm[k];
			accIm += firRe[k] * shadowIm[k] + firIm[k] * shadowRe[k];
		end
		expReQ.push_back(accRe);
		expImQ.push_back(accIm);
	endfunction

	// One clock cycle of stimulus, with an optional write and an optional sample.
	// A sample in the same cycle as a write is modelled with the old taps.
	task automatic driveCycle(input logic doWrite, input cfgOp_t op, input int addr,
		input int data, input logic doSample, input int sample);
		@(posedge clock);
		cfgWrite <= doWrite;
		cfgOp <= op;
		cfgAddr <= TapAddrWidth'(addr);
		cfgData <= CoeffWidth'(data);
		sampleValid <= doSample;
		sampleIn <= DataWidth'(sample);
		if (doSample) begin
			modelSample(sample);
		end
		if (doWrite) begin
			modelWrite(op, addr, data);
		end
	endtask

	task automatic writeTap(input cfgOp_t op, input int addr, input int data);
		driveCycle(1'b1, op, addr, data, 1'b0, 0);
	endtask

	task automatic sendSample(input int sample);
		driveCycle(1'b0, OpNop, 0, 0, 1'b1, sample);
	endtask

	// Idles the inputs and waits until every queued result has come out.
	task automatic drainOutputs();
		int waited;
		waited = 0;
		driveCycle(1'b0, OpNop, 0, 0, 1'b0, 0);
		while (expReQ.size() != 0 && waited < DrainLimit) begin
			@(negedge clock);
			waited++;
		end
		if (expReQ.size() != 0) begin
			$display("%s: %0d results never came out of the DUT", currentTest, expReQ.size());
			protocolErrors++;
			expReQ.delete();
			expImQ.delete();
			strobeQ.delete();
		end
	endtask

	task automatic checkAllZero(input string name, input int count);
		checkValue({name, " output count"}, count, capRe.size());
		foreach (capRe[i]) begin
			checkValue({name, " outRe"}, 0, capRe[i]);
			checkValue({name, " outIm"}, 0, capIm[i]);
		end
	endtask

	// The monitor samples at the falling edge, where all DUT signals are settled.
	always @(negedge clock) begin
		int strobeCycle;
		cycleCount = cycleCount + 1;
		if (arstN) begin
			if (sampleValid) begin
				strobeQ.push_back(cycleCount);
			end
			if (outValid) begin
				capRe.push_back(outRe);
				capIm.push_back(outIm);
				if (expReQ.size() == 0) begin
					$display("%s: output at cycle %0d with no sample pending", currentTest,
						cycleCount);
					protocolErrors++;
				end else begin
					checkValue({currentTest, " outRe"}, expReQ.pop_front(), outRe);
					checkValue({currentTest, " outIm"}, expImQ.pop_front(), outIm);
				end
				if (strobeQ.size() != 0) begin
					strobeCycle = strobeQ.pop_front();
					if (cycleCount - strobeCycle != 3) begin
						$display("%s: output came %0d cycles after its sample instead of 3",
							currentTest, cycleCount - strobeCycle);
						protocolErrors++;
					end
				end
			end
		end
	end

	task automatic testReset();
		currentTest = "testReset";
		repeat (10) begin
			@(negedge clock);
			checkValue("testReset outValid", 0, outValid);
		end
		capRe.delete();
		capIm.delete();
		for (int i = 0; i < 8; i++) begin
			sendSample(37 * i - 120);
		end
		drainOutputs();
		checkAllZero("testReset", 8);
	endtask

	// With only tap 0 set to one the output is the bare Hilbert response.
	task automatic testImpulse();
		longint wantRe [9];
		longint wantIm [9];
		currentTest = "testImpulse";
		writeTap(OpClear, 0, 0);
		writeTap(OpWriteRe, 0, 1);
		repeat (HtLength) sendSample(0);
		drainOutputs();
		capRe.delete();
		capIm.delete();
		sendSample(ImpulseAmp);
		repeat (8) sendSample(0);
		drainOutputs();
		foreach (wantRe[i]) begin
			wantRe[i] = 0;
			wantIm[i] = 0;
		end
		wantIm[0] = -HtCoeff3 * ImpulseAmp;
		wantIm[2] = -HtCoeff1 * ImpulseAmp;
		wantRe[3] = ImpulseAmp * 128;
		wantIm[4] = HtCoeff1 * ImpulseAmp;
		wantIm[6] = HtCoeff3 * ImpulseAmp;
		checkValue("testImpulse output count", 9, capRe.size());
		for (int i = 0; i < 9 && i < capRe.size(); i++) begin
			checkValue("testImpulse pattern re", wantRe[i], capRe[i]);
			checkValue("testImpulse pattern im", wantIm[i], capIm[i]);
		end
	endtask

	task automatic testComplexTap();
		currentTest = "testComplexTap";
		writeTap(OpClear, 0, 0);
		writeTap(OpWriteRe, 0, 3);
		writeTap(OpWriteIm, 0, -2);
		writeTap(OpWriteRe, 2, -5);
		writeTap(OpWriteIm, 2, 7);
		writeTap(OpWriteRe, 5, 11);
		writeTap(OpWriteIm, 5, 4);
		writeTap(OpWriteIm, 7, -6);
		for (int i = 0; i < 12; i++) begin
			sendSample((i * 173) % 401 - 200);
		end
		drainOutputs();
	endtask

	// A write strobed with a sample must not reach that sample.
	task automatic testClear();
		currentTest = "testClear";
		writeTap(OpClear, 0, 0);
		capRe.delete();
		capIm.delete();
		for (int i = 0; i < 10; i++) begin
			sendSample(50 * i - 200);
		end
		drainOutputs();
		checkAllZero("testClear", 10);
		capRe.delete();
		capIm.delete();
		driveCycle(1'b1, OpWriteRe, 1, 5, 1'b1, 300);
		for (int i = 0; i < 4; i++) begin
			sendSample(-90 + 60 * i);
		end
		drainOutputs();
		checkValue("testClear output count", 5, capRe.size());
		checkValue("testClear same-cycle re", 0, capRe[0]);
		checkValue("testClear same-cycle im", 0, capIm[0]);
	endtask

	task automatic testRandomStream();
		int sample;
		currentTest = "testRandomStream";
		writeTap(OpClear, 0, 0);
		for (int k = 0; k < NumTaps; k++) begin
			writeTap(OpWriteRe, k, $random(seed) % 2048);
			writeTap(OpWriteIm, k, $random(seed) % 2048);
		end
		for (int i = 0; i < 200; i++) begin
			sample = $random(seed) % 2048;
			if (($random(seed) & 7) == 0) begin
				driveCycle(1'b0, OpNop, 0, 0, 1'b0, 0);
			end
			// Now and then a tap changes in the same cycle as a sample.
			if (i % 50 == 25) begin
				driveCycle(1'b1, (i % 100 == 25) ? OpWriteRe : OpWriteIm, i % NumTaps,
					$random(seed) % 2048, 1'b1, sample);
			end else begin
				sendSample(sample);
			end
		end
		drainOutputs();
	endtask

	initial begin
		arstN = 1'b0;
		cfgWrite = 1'b0;
		cfgOp = OpNop;
		cfgAddr = '0;
		cfgData = '0;
		sampleValid = 1'b0;
		sampleIn = '0;
		seed = 32'he94b;
		foreach (htLine[k]) htLine[k] = 0;
		for (int k = 0; k < NumTaps; k++) begin
			firRe[k] = 0;
			firIm[k] = 0;
			shadowRe[k] = 0;
			shadowIm[k] = 0;
		end
		repeat (ResetCycles) @(posedge clock);
		arstN <= 1'b1;
		testReset();
		testImpulse();
		testComplexTap();
		testClear();
		testRandomStream();
		$display("Value mismatches: %0d, protocol errors: %0d", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Ends a run that outlasts the summed test budgets.
	initial begin
		#(TotalCycles * ClockPeriod);
		$display("Watchdog expired after %0d cycles, the tests did not finish", TotalCycles);
		$display("Test failed");
		$finish;
	end

endmodule

//--- tb.f
hdl/mfPkg.sv
hdl/mfCoeffRegs.sv
hdl/hilbertTransform.sv
hdl/complexFir.sv
hdl/matchedFilter.sv
dv/tbMatchedFilter.sv

//--- Bender.yml
package:
  name: matched_filter

sources:
  - target: rtl
    files:
      - hdl/mfPkg.sv
      - hdl/mfCoeffRegs.sv
      - hdl/hilbertTransform.sv
      - hdl/complexFir.sv
      - hdl/matchedFilter.sv
  - target: test
    files:
      - dv/tbMatchedFilter.sv
